/* conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

//============================
// datapath widths
//============================

// sample, weight and result word
`define CONV_DWIDTH 16

// qbits, kern and img_width fields
`define CONV_LWIDTH 8

// image memory address bits
`define CONV_MEMSIZE 8

//============================
// kernel and buffering
//============================

`define CONV_KERN_MAX 4

// network store address, taps plus one bias word
`define CONV_NETSIZE 3

`define CONV_FIFO_DEPTH 4

`endif

/* conv_pkg.sv */
`include "conv_config.svh"

package conv_pkg;

  // sample on its way to the mac unit
  typedef struct packed {
    logic signed [`CONV_DWIDTH-1:0] data;
    logic                           last;
  } pix_t;

  // result on its way back to memory
  typedef struct packed {
    logic signed [`CONV_DWIDTH-1:0] data;
    logic                           last;
  } res_t;

  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_INPUT   = 2'd2,
    S_OUTPUT  = 2'd3
  } core_state_e;

endpackage

/* conv_stream_if.sv */
`timescale 1ns/100ps

interface conv_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t data;

  // producer side
  modport src (
    output valid,
    output data,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* conv_img_mem.sv */
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_img_mem (
  input  logic                           clk,
  input  logic                           host_we,
  input  logic [`CONV_MEMSIZE-1:0]       host_addr,
  input  logic signed [`CONV_DWIDTH-1:0] host_wdata,
  output logic signed [`CONV_DWIDTH-1:0] host_rdata,
  input  logic [`CONV_MEMSIZE-1:0]       core_raddr,
  output logic signed [`CONV_DWIDTH-1:0] core_rdata,
  input  logic                           core_we,
  input  logic [`CONV_MEMSIZE-1:0]       core_waddr,
  input  logic signed [`CONV_DWIDTH-1:0] core_wdata
);

  localparam int WORDS = 1 << `CONV_MEMSIZE;

  logic signed [`CONV_DWIDTH-1:0] mem [WORDS];
  logic                           we;
  logic [`CONV_MEMSIZE-1:0]       waddr;
  logic signed [`CONV_DWIDTH-1:0] wdata;

  // host port wins the write path
  assign we    = host_we || core_we;
  assign waddr = host_we ? host_addr : core_waddr;
  assign wdata = host_we ? host_wdata : core_wdata;

  always_ff @(posedge clk)
    if (we)
      mem[waddr] <= wdata;

  assign host_rdata = mem[host_addr];
  assign core_rdata = mem[core_raddr];

  // host must stay off the memory while the core writes results
  assert property (@(posedge clk) !(host_we === 1'b1 && core_we === 1'b1));

endmodule

/* conv_stream_fifo.sv */
`timescale 1ns/100ps

module conv_stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic       clk,
  input  logic       xrst,
  conv_stream_if.dst in,
  conv_stream_if.src out
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      buf_mem [DEPTH];
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  assign in.ready  = count < DEPTH;
  assign out.valid = count != '0;
  assign out.data  = buf_mem[rptr];

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clk)
    if (push)
      buf_mem[wptr] <= in.data;

  //============================
  // pointers and fill level
  //============================

  always_ff @(posedge clk)
    if (!xrst) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else begin
      if (push)
        wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (pop)
        rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end

  assert property (@(posedge clk) disable iff (!xrst) count <= DEPTH);

endmodule

/* conv_mac_unit.sv */
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_mac_unit (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic [`CONV_KERN_MAX-1:0]      coef_we,
  input  logic                           bias_we,
  input  logic signed [`CONV_DWIDTH-1:0] coef_data,
  input  logic [`CONV_LWIDTH-1:0]        qbits,
  input  logic [`CONV_LWIDTH-1:0]        kern,
  input  logic                           relu_en,
  conv_stream_if.dst                     in,
  conv_stream_if.src                     out
);

  localparam int DW   = `CONV_DWIDTH;
  localparam int KMAX = `CONV_KERN_MAX;
  localparam int ACCW = 2 * DW + $clog2(KMAX) + 2;
  localparam int CW   = $clog2(KMAX + 1);

  logic signed [DW-1:0]   coef [KMAX];
  logic signed [DW-1:0]   bias;
  logic signed [DW-1:0]   win [KMAX];
  logic signed [DW-1:0]   nxt_win [KMAX];
  logic [CW-1:0]          win_cnt;
  logic [CW-1:0]          nxt_cnt;
  logic signed [ACCW-1:0] acc;
  logic signed [ACCW-1:0] shifted;
  logic signed [DW-1:0]   result;
  logic                   take;
  logic                   fire;
  logic                   out_valid;
  conv_pkg::res_t         out_data;

  assign in.ready  = !out_valid || out.ready;
  assign take      = in.valid && in.ready;
  assign out.valid = out_valid;
  assign out.data  = out_data;

  always_ff @(posedge clk) begin
    for (int i = 0; i < KMAX; i++)
      if (coef_we[i])
        coef[i] <= coef_data;
    if (bias_we)
      bias <= coef_data;
  end

  // newest sample at index 0
  always_comb begin
    nxt_win[0] = in.data.data;
    for (int i = 1; i < KMAX; i++)
      nxt_win[i] = win[i-1];
  end

  always_ff @(posedge clk)
    if (take)
      win <= nxt_win;

  assign nxt_cnt = (win_cnt == CW'(KMAX)) ? win_cnt : win_cnt + 1'b1;
  assign fire    = take && nxt_cnt >= kern;

  always_ff @(posedge clk)
    if (!xrst)
      win_cnt <= '0;
    else if (take)
      win_cnt <= in.data.last ? '0 : nxt_cnt;

  // taps occupy the top kern registers
  always_comb begin
    acc = ACCW'(bias);
    for (int i = 0; i < KMAX; i++)
      if (i + kern >= KMAX)
        acc = acc + coef[i] * nxt_win[KMAX-1-i];
    shifted = acc >>> qbits;
    result  = shifted[DW-1:0];
    if (relu_en && result[DW-1])
      result = '0;
  end

  always_ff @(posedge clk)
    if (!xrst)
      out_valid <= 1'b0;
    else if (fire)
      out_valid <= 1'b1;
    else if (out.ready)
      out_valid <= 1'b0;

  always_ff @(posedge clk)
    if (fire) begin
      out_data.data <= result;
      out_data.last <= in.data.last;
    end

endmodule

/* conv_ctrl_core.sv */
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_ctrl_core (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           req,
  input  logic [`CONV_LWIDTH-1:0]        kern,
  input  logic [`CONV_LWIDTH-1:0]        img_width,
  input  logic [`CONV_LWIDTH-1:0]        qbits,
  input  logic [`CONV_MEMSIZE-1:0]       in_offset,
  input  logic [`CONV_MEMSIZE-1:0]       out_offset,
  input  logic                           relu_en,
  input  logic                           bias_en,
  input  logic                           net_we,
  input  logic [`CONV_NETSIZE-1:0]       net_addr,
  input  logic signed [`CONV_DWIDTH-1:0] net_wdata,
  output logic                           ack,
  output conv_pkg::core_state_e          core_state,
  output logic [`CONV_MEMSIZE-1:0]       mem_raddr,
  input  logic signed [`CONV_DWIDTH-1:0] mem_rdata,
  output logic                           mem_we,
  output logic [`CONV_MEMSIZE-1:0]       mem_waddr,
  output logic signed [`CONV_DWIDTH-1:0] mem_wdata,
  conv_stream_if.src                     pix,
  conv_stream_if.dst                     res,
  output logic [`CONV_KERN_MAX-1:0]      coef_we,
  output logic                           bias_we,
  output logic signed [`CONV_DWIDTH-1:0] coef_data,
  output logic [`CONV_LWIDTH-1:0]        qbits_q,
  output logic [`CONV_LWIDTH-1:0]        kern_q,
  output logic                           relu_en_q
);

  localparam int DW   = `CONV_DWIDTH;
  localparam int LW   = `CONV_LWIDTH;
  localparam int MW   = `CONV_MEMSIZE;
  localparam int NW   = `CONV_NETSIZE;
  localparam int KMAX = `CONV_KERN_MAX;

  conv_pkg::core_state_e state;

  logic signed [DW-1:0] net_mem [KMAX+1];
  logic                 req_q;
  logic                 req_edge;
  logic                 start;
  logic [LW-1:0]        img_width_q;
  logic [MW-1:0]        in_offset_q;
  logic [MW-1:0]        out_offset_q;
  logic                 bias_en_q;
  logic [LW-1:0]        tap_cnt;
  logic                 tap_last;
  logic [NW-1:0]        net_sel;
  logic [LW-1:0]        rd_cnt;
  logic                 pix_last;
  logic                 pix_take;
  logic [MW-1:0]        wr_cnt;
  logic                 res_take;
  logic                 last_wr;

//============================
// core control
//============================

  assign req_edge   = req && !req_q;
  assign start      = state == conv_pkg::S_WAIT && req_edge;
  assign core_state = state;

  always_ff @(posedge clk)
    if (!xrst)
      req_q <= 1'b0;
    else
      req_q <= req;

  always_ff @(posedge clk)
    if (!xrst)
      state <= conv_pkg::S_WAIT;
    else
      case (state)
        conv_pkg::S_WAIT:
          if (req_edge)
            state <= conv_pkg::S_NETWORK;
        conv_pkg::S_NETWORK:
          if (tap_last)
            state <= conv_pkg::S_INPUT;
        conv_pkg::S_INPUT:
          if (pix_take && pix_last)
            state <= conv_pkg::S_OUTPUT;
        conv_pkg::S_OUTPUT:
          if (last_wr)
            state <= conv_pkg::S_WAIT;
        default:
          state <= conv_pkg::S_WAIT;
      endcase

  always_ff @(posedge clk)
    if (!xrst)
      ack <= 1'b1;
    else if (start)
      ack <= 1'b0;
    else if (last_wr)
      ack <= 1'b1;

  // layer parameters, held for the whole run
  always_ff @(posedge clk)
    if (!xrst) begin
      kern_q       <= '0;
      img_width_q  <= '0;
      qbits_q      <= '0;
      in_offset_q  <= '0;
      out_offset_q <= '0;
      relu_en_q    <= 1'b0;
      bias_en_q    <= 1'b0;
    end
    else if (start) begin
      kern_q       <= kern;
      img_width_q  <= img_width;
      qbits_q      <= qbits;
      in_offset_q  <= in_offset;
      out_offset_q <= out_offset;
      relu_en_q    <= relu_en;
      bias_en_q    <= bias_en;
    end

//============================
// network control
//============================

  always_ff @(posedge clk)
    if (net_we)
      net_mem[net_addr] <= net_wdata;

  // one tap per cycle, bias on the last one
  assign tap_last  = tap_cnt == kern_q;
  assign net_sel   = tap_last ? NW'(KMAX) : tap_cnt[NW-1:0];
  assign coef_data = (tap_last && !bias_en_q) ? '0 : net_mem[net_sel];
  assign bias_we   = state == conv_pkg::S_NETWORK && tap_last;
  assign coef_we   = (state == conv_pkg::S_NETWORK && !tap_last)
                   ? KMAX'(1) << (tap_cnt + KMAX - kern_q)
                   : '0;

  always_ff @(posedge clk)
    if (!xrst)
      tap_cnt <= '0;
    else if (state == conv_pkg::S_NETWORK && !tap_last)
      tap_cnt <= tap_cnt + 1'b1;
    else
      tap_cnt <= '0;

//============================
// input and output control
//============================

  assign pix_last  = rd_cnt == img_width_q - 1'b1;
  assign pix_take  = pix.valid && pix.ready;
  assign mem_raddr = in_offset_q + MW'(rd_cnt);
  assign pix.valid = state == conv_pkg::S_INPUT;
  assign pix.data  = '{data: mem_rdata, last: pix_last};

  always_ff @(posedge clk)
    if (!xrst)
      rd_cnt <= '0;
    else if (state == conv_pkg::S_WAIT)
      rd_cnt <= '0;
    else if (pix_take)
      rd_cnt <= rd_cnt + 1'b1;

  // results may already arrive while samples are streaming
  assign res.ready = state == conv_pkg::S_INPUT || state == conv_pkg::S_OUTPUT;
  assign res_take  = res.valid && res.ready;

  always_ff @(posedge clk)
    if (!xrst) begin
      mem_we  <= 1'b0;
      last_wr <= 1'b0;
      wr_cnt  <= '0;
    end
    else begin
      mem_we  <= res_take;
      last_wr <= res_take && res.data.last;
      if (state == conv_pkg::S_WAIT)
        wr_cnt <= '0;
      else if (res_take)
        wr_cnt <= wr_cnt + 1'b1;
    end

  always_ff @(posedge clk)
    if (res_take) begin
      mem_waddr <= out_offset_q + wr_cnt;
      mem_wdata <= res.data.data;
    end

  assert property (@(posedge clk) disable iff (!xrst)
    state != conv_pkg::S_WAIT |-> kern_q >= 1 && kern_q <= KMAX);

  assert property (@(posedge clk) disable iff (!xrst) $onehot0(coef_we));

endmodule

/* conv_top.sv */
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_top (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           req,
  output logic                           ack,
  output conv_pkg::core_state_e          core_state,
  input  logic [`CONV_LWIDTH-1:0]        kern,
  input  logic [`CONV_LWIDTH-1:0]        img_width,
  input  logic [`CONV_LWIDTH-1:0]        qbits,
  input  logic [`CONV_MEMSIZE-1:0]       in_offset,
  input  logic [`CONV_MEMSIZE-1:0]       out_offset,
  input  logic                           bias_en,
  input  logic                           relu_en,
  input  logic                           net_we,
  input  logic [`CONV_NETSIZE-1:0]       net_addr,
  input  logic signed [`CONV_DWIDTH-1:0] net_wdata,
  input  logic                           host_we,
  input  logic [`CONV_MEMSIZE-1:0]       host_addr,
  input  logic signed [`CONV_DWIDTH-1:0] host_wdata,
  output logic signed [`CONV_DWIDTH-1:0] host_rdata
);

  logic [`CONV_MEMSIZE-1:0]       mem_raddr;
  logic signed [`CONV_DWIDTH-1:0] mem_rdata;
  logic                           mem_we;
  logic [`CONV_MEMSIZE-1:0]       mem_waddr;
  logic signed [`CONV_DWIDTH-1:0] mem_wdata;
  logic [`CONV_KERN_MAX-1:0]      coef_we;
  logic                           bias_we;
  logic signed [`CONV_DWIDTH-1:0] coef_data;
  logic [`CONV_LWIDTH-1:0]        qbits_q;
  logic [`CONV_LWIDTH-1:0]        kern_q;
  logic                           relu_en_q;

  conv_stream_if #(.payload_t(conv_pkg::pix_t)) pix_in ();
  conv_stream_if #(.payload_t(conv_pkg::pix_t)) pix_out ();
  conv_stream_if #(.payload_t(conv_pkg::res_t)) res_in ();
  conv_stream_if #(.payload_t(conv_pkg::res_t)) res_out ();

  conv_ctrl_core core_i (
    .pix (pix_in),
    .res (res_out),
    .*
  );

  conv_img_mem mem_i (
    .clk        (clk),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .core_raddr (mem_raddr),
    .core_rdata (mem_rdata),
    .core_we    (mem_we),
    .core_waddr (mem_waddr),
    .core_wdata (mem_wdata)
  );

  // samples towards the mac unit
  conv_stream_fifo #(
    .payload_t (conv_pkg::pix_t),
    .DEPTH     (`CONV_FIFO_DEPTH)
  ) pix_fifo_i (
    .clk  (clk),
    .xrst (xrst),
    .in   (pix_in),
    .out  (pix_out)
  );

  conv_mac_unit mac_i (
    .clk       (clk),
    .xrst      (xrst),
    .coef_we   (coef_we),
    .bias_we   (bias_we),
    .coef_data (coef_data),
    .qbits     (qbits_q),
    .kern      (kern_q),
    .relu_en   (relu_en_q),
    .in        (pix_out),
    .out       (res_in)
  );

  // results back to the core
  conv_stream_fifo #(
    .payload_t (conv_pkg::res_t),
    .DEPTH     (`CONV_FIFO_DEPTH)
  ) res_fifo_i (
    .clk  (clk),
    .xrst (xrst),
    .in   (res_in),
    .out  (res_out)
  );

endmodule

/* conv_tb.sv */
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_tb;

  localparam int DW        = `CONV_DWIDTH;
  localparam int MW        = `CONV_MEMSIZE;
  localparam int NW        = `CONV_NETSIZE;
  localparam int KMAX      = `CONV_KERN_MAX;
  localparam int RUN_LIMIT = 400;

  logic                    clk;
  logic                    xrst;
  logic                    req;
  logic                    ack;
  conv_pkg::core_state_e   core_state;
  logic [`CONV_LWIDTH-1:0] kern;
  logic [`CONV_LWIDTH-1:0] img_width;
  logic [`CONV_LWIDTH-1:0] qbits;
  logic [MW-1:0]           in_offset;
  logic [MW-1:0]           out_offset;
  logic                    bias_en;
  logic                    relu_en;
  logic                    net_we;
  logic [NW-1:0]           net_addr;
  logic signed [DW-1:0]    net_wdata;
  logic                    host_we;
  logic [MW-1:0]           host_addr;
  logic signed [DW-1:0]    host_wdata;
  logic signed [DW-1:0]    host_rdata;

  integer seed = 46;
  int     errors = 0;
  string  test_name = "reset";

  // reference model state
  logic signed [DW-1:0] samples [64];
  logic signed [DW-1:0] taps [KMAX];
  logic signed [DW-1:0] bias_word;
  int                   m_kern;
  int                   m_qbits;
  logic                 m_bias_en;
  logic                 m_relu_en;

  conv_top dut_i (.*);

  always #2 clk = ~clk;

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [DW-1:0] exp,
                                 input logic [DW-1:0] act);
    abort_run($sformatf("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act));
  endtask

//============================
// concurrent checks
//============================

  // ack is high exactly while the core idles
  assert property (@(posedge clk) disable iff (!xrst)
    ack == (core_state == conv_pkg::S_WAIT))
    else abort_run("ack does not follow the idle state of the core");

  assert property (@(posedge clk) disable iff (!xrst)
    $rose(req) && core_state == conv_pkg::S_WAIT |=>
      !ack && core_state == conv_pkg::S_NETWORK)
    else abort_run("a rising req in idle did not start a run on the next edge");

  assert property (@(posedge clk) disable iff (!xrst)
    req && $past(req) && core_state == conv_pkg::S_WAIT |=>
      ack && core_state == conv_pkg::S_WAIT)
    else abort_run("a req held high started another run");

//============================
// host side
//============================

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic write_mem(input int addr, input logic [DW-1:0] data);
    host_we    = 1'b1;
    host_addr  = MW'(addr);
    host_wdata = data;
    step();
    host_we = 1'b0;
  endtask

  task automatic read_mem(input int addr, output logic [DW-1:0] data);
    host_addr = MW'(addr);
    #1;
    data = host_rdata;
    step();
  endtask

  task automatic write_net(input int addr, input logic [DW-1:0] data);
    net_we    = 1'b1;
    net_addr  = NW'(addr);
    net_wdata = data;
    step();
    net_we = 1'b0;
  endtask

  function automatic logic [DW-1:0] sentinel(input logic [MW-1:0] addr);
    return {addr ^ 8'hC3, addr};
  endfunction

  task automatic load_taps(input bit negative);
    for (int j = 0; j < KMAX; j++) begin
      taps[j] = $random(seed) % 64;
      if (negative && taps[j] >= 0)
        taps[j] = -taps[j] - 1;
      write_net(j, taps[j]);
    end
    bias_word = $random(seed) % 512;
    write_net(KMAX, bias_word);
  endtask

  task automatic load_image(input int base, input int width);
    for (int i = 0; i < width; i++) begin
      samples[i] = $random(seed) % 1000;
      write_mem(base + i, samples[i]);
    end
  endtask

  // sum of taps over the window, bias, shift, wrap, relu
  function automatic logic [DW-1:0] expected_word(input int start);
    longint        acc;
    logic [DW-1:0] word;
    acc = m_bias_en ? longint'(bias_word) : 64'sd0;
    for (int j = 0; j < m_kern; j++)
      acc += longint'(taps[j]) * longint'(samples[start + j]);
    acc  = acc >>> m_qbits;
    word = acc[DW-1:0];
    if (m_relu_en && word[DW-1])
      word = '0;
    return word;
  endfunction

  task automatic run_layer(input int k, input int width, input int q, input int in_off,
                           input int out_off, input bit b_en, input bit r_en,
                           input bit hold_req);
    int cyc;
    kern       = k;
    img_width  = width;
    qbits      = q;
    in_offset  = MW'(in_off);
    out_offset = MW'(out_off);
    bias_en    = b_en;
    relu_en    = r_en;
    req        = 1'b1;
    step();
    assert (ack === 1'b0)
      else report_mismatch("ack on the edge after req", 1'b0, ack);
    // the run must keep using the latched copies
    kern       = 8'($random(seed));
    img_width  = 8'($random(seed));
    qbits      = 8'($random(seed));
    in_offset  = MW'($random(seed));
    out_offset = MW'($random(seed));
    bias_en    = !b_en;
    relu_en    = !r_en;
    if (!hold_req)
      req = 1'b0;
    cyc = 0;
    while (ack !== 1'b1 && cyc < RUN_LIMIT) begin
      step();
      cyc++;
    end
    if (ack !== 1'b1)
      abort_run("timeout while waiting for ack at the end of the run");
  endtask

  task automatic do_test(input string name, input int k, input int width, input int q,
                         input int in_off, input int out_off, input bit b_en,
                         input bit r_en, input bit neg_taps, input bit hold_req);
    int            nres;
    logic [DW-1:0] got;
    test_name = name;
    m_kern    = k;
    m_qbits   = q;
    m_bias_en = b_en;
    m_relu_en = r_en;
    nres      = width - k + 1;
    load_taps(neg_taps);
    load_image(in_off, width);
    for (int i = 0; i < nres + 3; i++)
      write_mem(out_off + i, sentinel(MW'(out_off + i)));
    run_layer(k, width, q, in_off, out_off, b_en, r_en, hold_req);
    for (int i = 0; i < nres; i++) begin
      read_mem(out_off + i, got);
      assert (got === expected_word(i))
        else report_mismatch($sformatf("result %0d", i), expected_word(i), got);
    end
    for (int i = nres; i < nres + 3; i++) begin
      read_mem(out_off + i, got);
      assert (got === sentinel(MW'(out_off + i)))
        else report_mismatch($sformatf("word %0d past the results", i - nres),
                             sentinel(MW'(out_off + i)), got);
    end
  endtask

//============================
// main sequence
//============================

  initial begin
    clk        = 1'b0;
    xrst       = 1'b0;
    req        = 1'b0;
    kern       = '0;
    img_width  = '0;
    qbits      = '0;
    in_offset  = '0;
    out_offset = '0;
    bias_en    = 1'b0;
    relu_en    = 1'b0;
    net_we     = 1'b0;
    net_addr   = '0;
    net_wdata  = '0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (16) @(posedge clk);
    #1;
    xrst = 1'b1;
    step();
    assert (ack === 1'b1)
      else report_mismatch("ack after reset", 1'b1, ack);
    assert (core_state === conv_pkg::S_WAIT)
      else report_mismatch("core_state after reset", conv_pkg::S_WAIT, core_state);

    do_test("relu_off", 3, 12, 2, 'h10, 'h80, 1'b1, 1'b0, 1'b0, 1'b0);
    do_test("relu_on", 3, 10, 1, 'h20, 'h90, 1'b1, 1'b1, 1'b1, 1'b0);
    do_test("kern_min", 1, 8, 0, 'h30, 'hA0, 1'b0, 1'b0, 1'b0, 1'b0);
    do_test("kern_max", KMAX, 9, 3, 'h40, 'hB0, 1'b0, 1'b0, 1'b0, 1'b0);
    do_test("req_held", 2, 6, 1, 'h50, 'hC0, 1'b1, 1'b0, 1'b0, 1'b1);

    // req still high here
    for (int i = 0; i < 20; i++) begin
      step();
      assert (ack === 1'b1 && core_state === conv_pkg::S_WAIT)
        else abort_run("the core left idle while req stayed high");
    end
    req = 1'b0;
    step();

    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
conv_pkg.sv
conv_stream_if.sv
conv_img_mem.sv
conv_stream_fifo.sv
conv_mac_unit.sv
conv_ctrl_core.sv
conv_top.sv
conv_tb.sv
